// File: common/memq_pkg.sv
// memq_pkg: shared widths, config register map, control bit positions, config reset values
`default_nettype none

package memq_pkg;

    // request address width, top level default
    localparam int addr_w = 8;

    // configuration port widths
    localparam int cfg_addr_w = 2;
    localparam int cfg_data_w = 8;

    // register map
    localparam logic [cfg_addr_w-1:0] reg_ctrl  = 2'd0;  // enable, read priority
    localparam logic [cfg_addr_w-1:0] reg_age   = 2'd1;  // write age limit, 0 = off
    localparam logic [cfg_addr_w-1:0] reg_stall = 2'd2;  // hazard stall count, read only
    localparam logic [cfg_addr_w-1:0] reg_occ   = 2'd3;  // queue occupancy, read only

    // control register bits
    localparam int ctrl_en_bit      = 0;  // issue enable
    localparam int ctrl_rdfirst_bit = 1;  // 1 = reads first, 0 = writes first

    // reset values of the writable registers
    // enable and reads first set out of reset
    localparam logic [cfg_data_w-1:0] rst_ctrl = 8'h03;
    // no age limit after reset
    localparam logic [cfg_data_w-1:0] rst_age  = 8'h00;

endpackage

`default_nettype wire

// File: common/sched_cfg_if.sv
// sched_cfg_if: controls and status between the config block and the scheduler, two modports
`timescale 1ns/1ps
`default_nettype none

interface sched_cfg_if #(
    parameter int DEPTH = 4,
    localparam int CNT_W = $clog2(DEPTH + 1)
);

    // controls, driven by the config registers
    logic                            sched_en;    // issue enable
    logic                            read_first;  // read priority mode
    logic [memq_pkg::cfg_data_w-1:0] age_limit;   // max consecutive read bypasses

    // status, driven by the scheduler
    logic                            stall_pulse; // one cycle per hazard-held granted edge
    logic [CNT_W-1:0]                rd_count;    // read queue occupancy
    logic [CNT_W-1:0]                wr_count;    // write queue occupancy

    modport cfg_side (
        output sched_en, read_first, age_limit,
        input  stall_pulse, rd_count, wr_count
    );

    modport sched_side (
        input  sched_en, read_first, age_limit,
        output stall_pulse, rd_count, wr_count
    );

endinterface

`default_nettype wire

// File: sched/request_fifo.sv
// request_fifo: circular request queue with occupancy count, head output and per-slot view
`timescale 1ns/1ps
`default_nettype none

module request_fifo #(
    parameter int ADDR_W = memq_pkg::addr_w,
    parameter int DEPTH  = 4,
    localparam int PTR_W = $clog2(DEPTH),
    localparam int CNT_W = $clog2(DEPTH + 1)
) (
    input  logic              clkin,
    input  logic              rst_n,
    input  logic              push,                 // enqueue push_addr at tail
    input  logic [ADDR_W-1:0] push_addr,
    input  logic              pop,                  // dequeue head, only when not empty
    output logic [ADDR_W-1:0] head_addr,            // oldest entry
    output logic [CNT_W-1:0]  count,                // occupancy 0..DEPTH
    output logic [DEPTH-1:0]  entry_valid,          // slot holds a queued request
    output logic [ADDR_W-1:0] entry_addr [DEPTH]    // slot contents for the hazard scan
);

    logic [ADDR_W-1:0] mem [DEPTH];   // address storage, no reset
    logic [PTR_W-1:0]  head;          // next slot to leave
    logic [PTR_W-1:0]  tail;          // next slot to fill
    logic [DEPTH-1:0]  slot_vld;

    // storage, write side only
    always_ff @(posedge clkin) begin
        if (push) begin
            mem[tail] <= push_addr;
        end
    end

    // pointers, count and slot flags
    // DEPTH is a power of two so the pointers wrap on their own
    always_ff @(posedge clkin) begin
        if (!rst_n) begin
            head     <= '0;
            tail     <= '0;
            count    <= '0;
            slot_vld <= '0;
        end else begin
            if (pop) begin
                head           <= head + 1'b1;
                slot_vld[head] <= 1'b0;      // freed slot
            end
            if (push) begin
                tail           <= tail + 1'b1;
                slot_vld[tail] <= 1'b1;      // credits keep tail off a live head
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;     // both or neither, occupancy unchanged
            endcase
        end
    end

    assign head_addr   = mem[head];
    assign entry_valid = slot_vld;
    assign entry_addr  = mem;

endmodule

`default_nettype wire

// File: sched/addr_hazard.sv
// addr_hazard: read head address against every valid write slot, raises hazard on a match
`timescale 1ns/1ps
`default_nettype none

module addr_hazard #(
    parameter int ADDR_W = memq_pkg::addr_w,
    parameter int DEPTH  = 4
) (
    input  logic [ADDR_W-1:0] rd_head_addr,          // oldest read
    input  logic              rd_nonempty,           // read head is meaningful
    input  logic [DEPTH-1:0]  wr_entry_valid,        // live write slots
    input  logic [ADDR_W-1:0] wr_entry_addr [DEPTH], // write slot addresses
    output logic              hazard                 // read head must wait
);

    logic [DEPTH-1:0] slot_hit;

    // per-slot compare
    // any live write slot with the read head's address blocks it
    always_comb begin
        for (int i = 0; i < DEPTH; i++) begin
            slot_hit[i] = wr_entry_valid[i] && (wr_entry_addr[i] == rd_head_addr);
        end
    end

    // combinational so a freshly issued write clears the hold at once
    // and a stale match never lets a read slip through
    assign hazard = rd_nonempty && (|slot_hit);

endmodule

`default_nettype wire

// File: sched/issue_sched.sv
// issue_sched: both queues, hazard check, issue choice, credit pulses, bypass and stall tracking
`timescale 1ns/1ps
`default_nettype none

module issue_sched #(
    parameter int ADDR_W = memq_pkg::addr_w,
    parameter int DEPTH  = 4,
    localparam int CNT_W = $clog2(DEPTH + 1)
) (
    input  logic                   clkin,
    input  logic                   rst_n,
    input  logic                   in_valid,     // upstream request, credit already spent
    input  logic                   in_read,      // 1 = read, 0 = write
    input  logic [ADDR_W-1:0]      in_addr,
    input  logic                   bus_gnt_raw,  // sampled every edge
    sched_cfg_if.sched_side        cfg,
    output logic                   out_valid,    // one cycle per issue
    output logic                   out_is_read,
    output logic [ADDR_W-1:0]      out_addr,
    output logic                   rd_credit,    // returns one read credit
    output logic                   wr_credit     // returns one write credit
);

    localparam logic [memq_pkg::cfg_data_w-1:0] byp_max = '1;

    logic                            gnt_q;         // registered grant
    logic                            rd_push, wr_push;
    logic                            rd_pop, wr_pop;
    logic [ADDR_W-1:0]               rd_head, wr_head;
    logic [CNT_W-1:0]                rd_cnt, wr_cnt;
    logic [DEPTH-1:0]                wr_vld;
    logic [ADDR_W-1:0]               wr_addrs [DEPTH];
    logic                            rd_nonempty, wr_nonempty;
    logic                            hazard;
    logic                            age_force;     // too many reads jumped the writes
    logic                            rd_elig, wr_elig;
    logic [memq_pkg::cfg_data_w-1:0] byp_cnt;       // consecutive read bypasses

    // steer arriving requests by class
    assign rd_push = in_valid && in_read;
    assign wr_push = in_valid && !in_read;

    // read slots need no scan
    request_fifo #(.ADDR_W(ADDR_W), .DEPTH(DEPTH)) rd_q (
        .clkin       (clkin),
        .rst_n       (rst_n),
        .push        (rd_push),
        .push_addr   (in_addr),
        .pop         (rd_pop),
        .head_addr   (rd_head),
        .count       (rd_cnt),
        .entry_valid (),
        .entry_addr  ()
    );

    request_fifo #(.ADDR_W(ADDR_W), .DEPTH(DEPTH)) wr_q (
        .clkin       (clkin),
        .rst_n       (rst_n),
        .push        (wr_push),
        .push_addr   (in_addr),
        .pop         (wr_pop),
        .head_addr   (wr_head),
        .count       (wr_cnt),
        .entry_valid (wr_vld),
        .entry_addr  (wr_addrs)
    );

    assign rd_nonempty = (rd_cnt != '0);
    assign wr_nonempty = (wr_cnt != '0);

    addr_hazard #(.ADDR_W(ADDR_W), .DEPTH(DEPTH)) u_hazard (
        .rd_head_addr   (rd_head),
        .rd_nonempty    (rd_nonempty),
        .wr_entry_valid (wr_vld),
        .wr_entry_addr  (wr_addrs),
        .hazard         (hazard)
    );

    // issue choice from the registered queue state
    // same-edge enqueues show up one edge later
    assign age_force = (cfg.age_limit != '0) && wr_nonempty && (byp_cnt == cfg.age_limit);
    assign rd_elig   = cfg.sched_en && rd_nonempty && !hazard && !age_force
                       && (cfg.read_first || !wr_nonempty);
    assign wr_elig   = cfg.sched_en && wr_nonempty && !rd_elig;

    // pops only on a granted edge
    assign rd_pop = gnt_q && rd_elig;
    assign wr_pop = gnt_q && wr_elig;

    // grant, issue outputs, credits, bypass count, stall pulse
    always_ff @(posedge clkin) begin
        if (!rst_n) begin
            gnt_q           <= 1'b0;
            out_valid       <= 1'b0;
            out_is_read     <= 1'b0;
            rd_credit       <= 1'b0;
            wr_credit       <= 1'b0;
            byp_cnt         <= '0;
            cfg.stall_pulse <= 1'b0;
        end else begin
            gnt_q       <= bus_gnt_raw;
            out_valid   <= rd_pop || wr_pop;
            out_is_read <= rd_pop;
            rd_credit   <= rd_pop;      // freed read slot goes back upstream
            wr_credit   <= wr_pop;
            if (wr_pop) begin
                byp_cnt <= '0;          // any write ends the bypass run
            end else if (rd_pop && wr_nonempty && byp_cnt != byp_max) begin
                byp_cnt <= byp_cnt + 1'b1;
            end
            // read head held by a write to the same address on a granted edge
            cfg.stall_pulse <= gnt_q && cfg.sched_en && hazard;
        end
    end

    // issued address, payload only
    always_ff @(posedge clkin) begin
        if (rd_pop) begin
            out_addr <= rd_head;
        end else if (wr_pop) begin
            out_addr <= wr_head;
        end
    end

    // occupancy status to the config block
    assign cfg.rd_count = rd_cnt;
    assign cfg.wr_count = wr_cnt;

endmodule

`default_nettype wire

// File: sched/sched_cfg.sv
// sched_cfg: control and age registers, saturating stall counter, occupancy readback, config port
`timescale 1ns/1ps
`default_nettype none

module sched_cfg (
    input  logic                            clkin,
    input  logic                            rst_n,
    input  logic                            cfg_wr,     // write strobe, takes effect this edge
    input  logic [memq_pkg::cfg_addr_w-1:0] cfg_addr,
    input  logic [memq_pkg::cfg_data_w-1:0] cfg_wdata,
    output logic [memq_pkg::cfg_data_w-1:0] cfg_rdata,  // combinational readback
    sched_cfg_if.cfg_side                   cfg
);

    localparam logic [memq_pkg::cfg_data_w-1:0] stall_max = '1;

    logic [memq_pkg::cfg_data_w-1:0] ctrl_q;     // enable and priority bits
    logic [memq_pkg::cfg_data_w-1:0] age_q;      // write age limit
    logic [memq_pkg::cfg_data_w-1:0] stall_cnt;  // hazard stalls seen
    logic [memq_pkg::cfg_data_w-1:0] occ;        // {wr count, rd count}

    // writable registers
    always_ff @(posedge clkin) begin
        if (!rst_n) begin
            ctrl_q <= memq_pkg::rst_ctrl;
            age_q  <= memq_pkg::rst_age;
        end else if (cfg_wr) begin
            case (cfg_addr)
                memq_pkg::reg_ctrl: ctrl_q <= cfg_wdata;
                memq_pkg::reg_age:  age_q  <= cfg_wdata;
                default: ;                     // stall and occupancy are read only
            endcase
        end
    end

    // stall counter, sticks at the top
    always_ff @(posedge clkin) begin
        if (!rst_n) begin
            stall_cnt <= '0;
        end else if (cfg.stall_pulse && stall_cnt != stall_max) begin
            stall_cnt <= stall_cnt + 1'b1;
        end
    end

    // occupancy nibbles
    assign occ = {4'(cfg.wr_count), 4'(cfg.rd_count)};

    // readback mux
    always_comb begin
        case (cfg_addr)
            memq_pkg::reg_ctrl:  cfg_rdata = ctrl_q;
            memq_pkg::reg_age:   cfg_rdata = age_q;
            memq_pkg::reg_stall: cfg_rdata = stall_cnt;
            default:             cfg_rdata = occ;   // reg_occ
        endcase
    end

    // controls out to the scheduler
    assign cfg.sched_en   = ctrl_q[memq_pkg::ctrl_en_bit];
    assign cfg.read_first = ctrl_q[memq_pkg::ctrl_rdfirst_bit];
    assign cfg.age_limit  = age_q;

endmodule

`default_nettype wire

// File: design/memq_top.sv
// memq_top: RTL top with the request scheduler, its config block and the link between them
`timescale 1ns/1ps
`default_nettype none

module memq_top #(
    parameter int ADDR_W = memq_pkg::addr_w,
    parameter int DEPTH  = 4                  // power of two
) (
    input  logic                            clkin,
    input  logic                            rst_n,
    // upstream requests, credit based
    input  logic                            in_valid,
    input  logic                            in_read,
    input  logic [ADDR_W-1:0]               in_addr,
    output logic                            rd_credit,
    output logic                            wr_credit,
    // bus side
    input  logic                            bus_gnt_raw,
    output logic                            out_valid,
    output logic                            out_is_read,
    output logic [ADDR_W-1:0]               out_addr,
    // config port
    input  logic                            cfg_wr,
    input  logic [memq_pkg::cfg_addr_w-1:0] cfg_addr,
    input  logic [memq_pkg::cfg_data_w-1:0] cfg_wdata,
    output logic [memq_pkg::cfg_data_w-1:0] cfg_rdata
);

    // controls down, status up
    sched_cfg_if #(.DEPTH(DEPTH)) cfg_bus ();

    sched_cfg u_cfg (
        .clkin     (clkin),
        .rst_n     (rst_n),
        .cfg_wr    (cfg_wr),
        .cfg_addr  (cfg_addr),
        .cfg_wdata (cfg_wdata),
        .cfg_rdata (cfg_rdata),
        .cfg       (cfg_bus.cfg_side)
    );

    issue_sched #(.ADDR_W(ADDR_W), .DEPTH(DEPTH)) u_sched (
        .clkin       (clkin),
        .rst_n       (rst_n),
        .in_valid    (in_valid),
        .in_read     (in_read),
        .in_addr     (in_addr),
        .bus_gnt_raw (bus_gnt_raw),
        .cfg         (cfg_bus.sched_side),
        .out_valid   (out_valid),
        .out_is_read (out_is_read),
        .out_addr    (out_addr),
        .rd_credit   (rd_credit),
        .wr_credit   (wr_credit)
    );

endmodule

`default_nettype wire

// File: test/memq_tb_checks.sv
// memq_tb_checks: reference model of both queues and the issue rule, assertions against the DUT
`timescale 1ns/1ps
`default_nettype none

module memq_tb_checks #(
    parameter int ADDR_W = memq_pkg::addr_w,
    parameter int DEPTH  = 4
) (
    input  logic                            clkin,
    input  logic                            rst_n,
    input  logic                            in_valid,
    input  logic                            in_read,
    input  logic [ADDR_W-1:0]               in_addr,
    input  logic                            bus_gnt_raw,
    input  logic                            cfg_wr,
    input  logic [memq_pkg::cfg_addr_w-1:0] cfg_addr,
    input  logic [memq_pkg::cfg_data_w-1:0] cfg_wdata,
    input  logic                            out_valid,
    input  logic                            out_is_read,
    input  logic [ADDR_W-1:0]               out_addr,
    input  logic                            rd_credit,
    input  logic                            wr_credit,
    input  int                              rd_bal,        // upstream credits held
    input  int                              wr_bal,
    output int                              rd_occ,        // model queue sizes
    output int                              wr_occ,
    output int                              model_stalls,  // hazard-held granted edges, saturating
    output int                              check_errs
);

    logic [ADDR_W-1:0] rd_q [$];   // model queues, oldest first
    logic [ADDR_W-1:0] wr_q [$];
    logic [7:0]        ctrl_m;     // mirrored config registers
    logic [7:0]        age_m;
    int                byp_m;      // read bypasses since last write
    logic              gnt_m;      // model of the registered grant
    logic              en, held, force_wr, take_rd, take_wr;
    logic              exp_valid, exp_read;   // expected issue outputs for this cycle
    logic [ADDR_W-1:0] exp_addr;
    logic              held_issue;            // read head was held at the issuing edge

    initial check_errs = 0;

    task log_mismatch(input string name, input int expv, input int actv);
        check_errs++;
        $display("ERROR %0t %s expected %0h actual %0h", $time, name, expv, actv);
    endtask

    task log_fail(input string what);
        check_errs++;
        $display("%0t check failed, %s", $time, what);
    endtask

    // issue decision on pre-edge state, then this edge's enqueue and config write
    always @(posedge clkin) begin
        if (!rst_n) begin
            rd_q.delete();
            wr_q.delete();
            ctrl_m       = memq_pkg::rst_ctrl;
            age_m        = memq_pkg::rst_age;
            byp_m        = 0;
            gnt_m        = 1'b0;
            exp_valid    = 1'b0;
            exp_read     = 1'b0;
            held_issue   = 1'b0;
            model_stalls = 0;
        end else begin
            en   = ctrl_m[memq_pkg::ctrl_en_bit];
            held = 1'b0;
            foreach (wr_q[i]) begin
                if (rd_q.size() != 0 && wr_q[i] == rd_q[0]) held = 1'b1;  // older write, same addr
            end
            force_wr = age_m != 0 && wr_q.size() != 0 && byp_m == age_m;
            take_rd  = en && rd_q.size() != 0 && !held && !force_wr
                       && (ctrl_m[memq_pkg::ctrl_rdfirst_bit] || wr_q.size() == 0);
            take_wr  = en && wr_q.size() != 0 && !take_rd;
            exp_valid  = gnt_m && (take_rd || take_wr);
            exp_read   = gnt_m && take_rd;
            held_issue = held;
            if (gnt_m && en && held && model_stalls != 255) model_stalls++;
            if (gnt_m && take_wr) begin
                exp_addr = wr_q.pop_front();
                byp_m    = 0;                     // a write ends the bypass run
            end else if (gnt_m && take_rd) begin
                if (wr_q.size() != 0 && byp_m != 255) byp_m++;
                exp_addr = rd_q.pop_front();
            end
            if (in_valid && in_read) rd_q.push_back(in_addr);
            if (in_valid && !in_read) wr_q.push_back(in_addr);
            if (cfg_wr && cfg_addr == memq_pkg::reg_ctrl) ctrl_m = cfg_wdata;
            if (cfg_wr && cfg_addr == memq_pkg::reg_age) age_m = cfg_wdata;
            gnt_m = bus_gnt_raw;
        end
        rd_occ = rd_q.size();
        wr_occ = wr_q.size();
    end

    a_valid: assert property (@(posedge clkin) disable iff (!rst_n) out_valid == exp_valid)
        else log_mismatch("out_valid", $sampled(exp_valid), $sampled(out_valid));
    a_class: assert property (@(posedge clkin) disable iff (!rst_n)
        !exp_valid || out_is_read == exp_read)
        else log_mismatch("out_is_read", $sampled(exp_read), $sampled(out_is_read));
    a_addr: assert property (@(posedge clkin) disable iff (!rst_n)
        !exp_valid || out_addr == exp_addr)
        else log_mismatch("out_addr", $sampled(exp_addr), $sampled(out_addr));
    a_rd_credit: assert property (@(posedge clkin) disable iff (!rst_n)
        rd_credit == (exp_valid && exp_read))
        else log_mismatch("rd_credit", $sampled(exp_valid && exp_read), $sampled(rd_credit));
    a_wr_credit: assert property (@(posedge clkin) disable iff (!rst_n)
        wr_credit == (exp_valid && !exp_read))
        else log_mismatch("wr_credit", $sampled(exp_valid && !exp_read), $sampled(wr_credit));
    a_grant: assert property (@(posedge clkin) disable iff (!rst_n)
        out_valid |-> $past(bus_gnt_raw, 2))
        else log_fail("out_valid high without a grant sampled two edges earlier");
    a_hold: assert property (@(posedge clkin) disable iff (!rst_n)
        !(out_valid && out_is_read && held_issue))
        else log_fail("a read passed an older queued write to the same address");
    a_credit_range: assert property (@(posedge clkin) disable iff (!rst_n)
        rd_bal >= 0 && rd_bal <= DEPTH && wr_bal >= 0 && wr_bal <= DEPTH)
        else log_fail("upstream credit balance left the range 0 to DEPTH");

endmodule

`default_nettype wire

// File: test/memq_tb.sv
// memq_tb: clock, reset, DUT, upstream credit model, random and directed stimulus, closing report
`timescale 1ns/1ps
`default_nettype none

module memq_tb;

    localparam int ADDR_W = memq_pkg::addr_w;
    localparam int DEPTH  = 4;

    logic              clkin, rst_n;
    logic              in_valid, in_read, bus_gnt_raw, cfg_wr;
    logic [ADDR_W-1:0] in_addr, out_addr;
    logic              out_valid, out_is_read, rd_credit, wr_credit;
    logic [1:0]        cfg_addr;
    logic [7:0]        cfg_wdata, cfg_rdata;
    int                seed;
    int                rd_bal, wr_bal;          // credits held by the sender
    int                rd_occ, wr_occ, model_stalls, check_errs;
    int                tb_errs;

    always #5 clkin = ~clkin;

    memq_top #(.ADDR_W(ADDR_W), .DEPTH(DEPTH)) DUT (
        .clkin(clkin), .rst_n(rst_n),
        .in_valid(in_valid), .in_read(in_read), .in_addr(in_addr),
        .rd_credit(rd_credit), .wr_credit(wr_credit),
        .bus_gnt_raw(bus_gnt_raw), .out_valid(out_valid),
        .out_is_read(out_is_read), .out_addr(out_addr),
        .cfg_wr(cfg_wr), .cfg_addr(cfg_addr), .cfg_wdata(cfg_wdata), .cfg_rdata(cfg_rdata)
    );

    memq_tb_checks #(.ADDR_W(ADDR_W), .DEPTH(DEPTH)) chk (
        .clkin(clkin), .rst_n(rst_n),
        .in_valid(in_valid), .in_read(in_read), .in_addr(in_addr),
        .bus_gnt_raw(bus_gnt_raw), .cfg_wr(cfg_wr), .cfg_addr(cfg_addr), .cfg_wdata(cfg_wdata),
        .out_valid(out_valid), .out_is_read(out_is_read), .out_addr(out_addr),
        .rd_credit(rd_credit), .wr_credit(wr_credit), .rd_bal(rd_bal), .wr_bal(wr_bal),
        .rd_occ(rd_occ), .wr_occ(wr_occ), .model_stalls(model_stalls), .check_errs(check_errs)
    );

    // upstream credit model, a send costs one and a pulse returns one
    always @(posedge clkin) begin
        if (!rst_n) begin
            rd_bal = DEPTH;
            wr_bal = DEPTH;
        end else begin
            rd_bal += int'(rd_credit) - int'(in_valid && in_read);
            wr_bal += int'(wr_credit) - int'(in_valid && !in_read);
        end
    end

    task tick();
        @(posedge clkin);
        #1;                                     // drive point
    endtask

    task drive_random();
        logic rd;
        rd          = $random(seed) & 1;
        in_read     = rd;
        in_addr     = 8'h40 + ($random(seed) & 3);   // small pool, frequent hazards
        in_valid    = ($random(seed) & 1) && (rd ? rd_bal > 0 : wr_bal > 0);
        bus_gnt_raw = $random(seed) & 1;
    endtask

    task random_phase(input int cycles);
        repeat (cycles) begin
            drive_random();
            tick();
        end
        in_valid = 1'b0;
    endtask

    task send_req(input logic rd, input logic [ADDR_W-1:0] a);
        int t;
        t = 0;
        while ((rd ? rd_bal : wr_bal) == 0 && t < 100) begin
            tick();
            t++;
        end
        if ((rd ? rd_bal : wr_bal) == 0) begin
            tb_errs++;
            $display("%0t timeout, no credit came back for a request", $time);
        end else begin
            in_valid = 1'b1;
            in_read  = rd;
            in_addr  = a;
            tick();
            in_valid = 1'b0;
        end
    endtask

    task drain();
        int t;
        t           = 0;
        in_valid    = 1'b0;
        bus_gnt_raw = 1'b1;
        while ((rd_occ != 0 || wr_occ != 0) && t < 200) begin
            tick();
            t++;
        end
        if (rd_occ != 0 || wr_occ != 0) begin
            tb_errs++;
            $display("%0t timeout, queues did not drain", $time);
        end
        repeat (4) tick();                      // last credits and stall count settle
    endtask

    task write_reg(input logic [1:0] a, input logic [7:0] d);
        cfg_wr    = 1'b1;
        cfg_addr  = a;
        cfg_wdata = d;
        tick();
        cfg_wr    = 1'b0;
    endtask

    task check_reg(input logic [1:0] a, input logic [7:0] expv, input string name);
        cfg_addr = a;
        tick();                                 // readback is combinational, settled by now
        assert (cfg_rdata === expv)
        else begin
            tb_errs++;
            $display("ERROR %0t %s expected %0h actual %0h", $time, name, expv, cfg_rdata);
        end
    endtask

    task check_credits();
        assert (rd_bal == DEPTH && wr_bal == DEPTH)
        else begin
            tb_errs++;
            $display("ERROR %0t rd_bal/wr_bal expected %0d/%0d actual %0d/%0d",
                     $time, DEPTH, DEPTH, rd_bal, wr_bal);
        end
    endtask

    task finish_run();
        $display("errors: assertions %0d, testbench %0d", check_errs, tb_errs);
        if (check_errs == 0 && tb_errs == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    endtask

    initial begin
        clkin       = 1'b0;
        rst_n       = 1'b0;
        in_valid    = 1'b0;
        in_read     = 1'b0;
        in_addr     = '0;
        bus_gnt_raw = 1'b0;
        cfg_wr      = 1'b0;
        cfg_addr    = '0;
        cfg_wdata   = '0;
        seed        = 44224;
        tb_errs     = 0;
        repeat (10) @(posedge clkin);
        #1 rst_n = 1'b1;
        check_reg(memq_pkg::reg_ctrl, memq_pkg::rst_ctrl, "ctrl");
        check_reg(memq_pkg::reg_age, memq_pkg::rst_age, "age");
        check_reg(memq_pkg::reg_stall, 8'h00, "stall");
        check_reg(memq_pkg::reg_occ, 8'h00, "occ");
        // mixed traffic, reads first
        random_phase(400);
        drain();
        check_credits();
        check_reg(memq_pkg::reg_stall, 8'(model_stalls), "stall");
        // read behind a write to the same address
        bus_gnt_raw = 1'b0;
        send_req(1'b0, 8'h50);
        send_req(1'b1, 8'h50);
        send_req(1'b1, 8'h51);
        drain();
        check_credits();
        check_reg(memq_pkg::reg_stall, 8'(model_stalls), "stall");
        // age limit, write forced after two bypasses
        write_reg(memq_pkg::reg_age, 8'd2);
        bus_gnt_raw = 1'b0;
        send_req(1'b0, 8'h20);
        send_req(1'b1, 8'h31);
        send_req(1'b1, 8'h32);
        send_req(1'b1, 8'h33);
        send_req(1'b0, 8'h21);
        drain();
        write_reg(memq_pkg::reg_age, 8'd0);
        // writes first
        write_reg(memq_pkg::reg_ctrl, 8'h01);
        random_phase(150);
        drain();
        // issue disabled, nothing may leave
        write_reg(memq_pkg::reg_ctrl, 8'h00);
        send_req(1'b1, 8'h60);
        send_req(1'b0, 8'h61);
        bus_gnt_raw = 1'b1;
        repeat (30) tick();
        write_reg(memq_pkg::reg_ctrl, memq_pkg::rst_ctrl);
        drain();
        // long stretch with the grant low
        bus_gnt_raw = 1'b0;
        send_req(1'b1, 8'h70);
        send_req(1'b0, 8'h71);
        send_req(1'b0, 8'h72);
        repeat (40) tick();
        check_reg(memq_pkg::reg_occ, 8'((wr_occ << 4) | rd_occ), "occ");
        drain();
        check_credits();
        check_reg(memq_pkg::reg_stall, 8'(model_stalls), "stall");
        finish_run();
    end

endmodule

`default_nettype wire

// File: flist.f
common/memq_pkg.sv
common/sched_cfg_if.sv
sched/request_fifo.sv
sched/addr_hazard.sv
sched/issue_sched.sv
sched/sched_cfg.sv
design/memq_top.sv
test/memq_tb_checks.sv
test/memq_tb.sv
